/* verilog.f */
+incdir+design
design/wave_pkg.sv
design/bus_pkg.sv
design/apb_regs.sv
design/node_sweep.sv
design/patch_memory.sv
design/node_update.sv
design/patch_top.sv
test/clock_gen.sv
test/tb_patch.sv

/* Bender.yml */
package:
  name: wave_patch

sources:
  - include_dirs:
      - design
    files:
      - design/wave_pkg.sv
      - design/bus_pkg.sv
      - design/apb_regs.sv
      - design/node_sweep.sv
      - design/patch_memory.sv
      - design/node_update.sv
      - design/patch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/clock_gen.sv
      - test/tb_patch.sv

/* test/tb_patch.sv */
`include "patch_cfg.svh"

module tb_patch;
	import bus_pkg::*;

	localparam int PERIOD   = 20;
	localparam int DIM      = `PATCH_DIM;
	localparam int NODES    = DIM * DIM;
	localparam int APB_WAIT = 4000;    // cycles per transfer
	localparam int POLLS    = 1000;    // status reads per run

	logic     clock;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     sweep_done;

	int seed = 92304;
	int errors;
	int checks;
	int done_pulses;

	int model_prev [NODES];    // reference planes in row major order
	int model_curr [NODES];
	int edge_right;
	int edge_left;
	int edge_up;
	int edge_down;
	int rho_val;

	string       chk_name [$];    // pending compares
	logic [31:0] chk_got [$];
	logic [31:0] chk_exp [$];
	string       cur_name;
	logic [31:0] cur_got;
	logic [31:0] cur_exp;

	clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) i_clock_gen (.clock(clock), .reset(reset));

	patch_top i_dut (
		.clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.sweep_done(sweep_done)
	);

	function automatic logic [31:0] sext(int value);
		return {{(32 - `NODE_W){value[`NODE_W-1]}}, value[`NODE_W-1:0]};
	endfunction

	function automatic int wrap_node(longint value);
		return sext(int'(value));
	endfunction

	function automatic int neighbor(int row, int col, int boundary);
		if (row < 0 || row >= DIM || col < 0 || col >= DIM)
			return boundary;    // outside the patch
		return model_curr[row * DIM + col];
	endfunction

	// discrete wave step for one node
	function automatic int expect_next(int row, int col);
		int     center;
		longint lap;
		longint scaled;
		center = model_curr[row * DIM + col];
		lap    = neighbor(row, col + 1, edge_right) + neighbor(row, col - 1, edge_left) +
			neighbor(row - 1, col, edge_up) + neighbor(row + 1, col, edge_down) - 4 * center;
		scaled = (lap * rho_val) >>> `RHO_FRAC;
		return wrap_node(2 * center - model_prev[row * DIM + col] + scaled);
	endfunction

	task automatic model_sweep();
		int next_plane [NODES];
		for (int n = 0; n < NODES; n++)
			next_plane[n] = expect_next(n / DIM, n % DIM);
		model_prev = model_curr;    // rotation
		model_curr = next_plane;
	endtask

	function automatic logic [7:0] node_addr(int n);
		return 8'h40 | 8'((n / DIM) << 4) | 8'((n % DIM) << 2);
	endfunction

	function automatic logic [7:0] reg_addr(reg_sel_t sel);
		return {3'b000, sel, 2'b00};
	endfunction

	task automatic expect_value(string name, logic [31:0] got, logic [31:0] exp);
		chk_name.push_back(name);
		chk_got.push_back(got);
		chk_exp.push_back(exp);
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic report_timeout(string what);
		errors++;
		$display("timeout: %s", what);
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		logic done;
		int   waited;
		done   = 1'b0;
		waited = 0;
		rdata  = '0;
		slverr = 1'b0;
		@(negedge clock);
		apb_req.psel    = 1'b1;    // setup
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clock);
		apb_req.penable = 1'b1;
		while (!done && waited < APB_WAIT) begin
			#(PERIOD / 4);    // mid low phase
			if (apb_rsp.pready) begin
				rdata  = apb_rsp.prdata;
				slverr = apb_rsp.pslverr;
				done   = 1'b1;
			end
			@(negedge clock);
			waited++;
		end
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		if (!done)
			report_timeout($sformatf("pready never came for address %h", addr));
	endtask

	task automatic write_word(logic [7:0] addr, int data, logic exp_err);
		logic [31:0] rdata;
		logic        slverr;
		apb_transfer(1'b1, addr, data, rdata, slverr);
		expect_value($sformatf("pslverr of write to %h", addr), 32'(slverr), 32'(exp_err));
	endtask

	task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
		logic slverr;
		apb_transfer(1'b0, addr, '0, data, slverr);
	endtask

	task automatic check_reg(string name, reg_sel_t sel, int value);
		logic [31:0] word;
		read_word(reg_addr(sel), word);
		expect_value(name, word, sext(value));
	endtask

	task automatic check_nodes();
		logic [31:0] word;
		for (int n = 0; n < NODES; n++) begin
			read_word(node_addr(n), word);
			expect_value($sformatf("prdata of node %0d,%0d", n / DIM, n % DIM), word,
				sext(model_curr[n]));
		end
	endtask

	task automatic set_edges(int right, int left, int up, int down);
		write_word(reg_addr(sel_edge_right), right, 1'b0);
		write_word(reg_addr(sel_edge_left), left, 1'b0);
		write_word(reg_addr(sel_edge_up), up, 1'b0);
		write_word(reg_addr(sel_edge_down), down, 1'b0);
		edge_right = right;
		edge_left  = left;
		edge_up    = up;
		edge_down  = down;
	endtask

	task automatic wait_idle(output logic [31:0] status);
		int polls;
		polls = 0;
		read_word(reg_addr(sel_status), status);
		while (status[0] && polls < POLLS) begin
			read_word(reg_addr(sel_status), status);
			polls++;
		end
		if (status[0])
			report_timeout("busy stayed set after the run");
	endtask

	always @(negedge clock) begin
		while (chk_name.size() > 0) begin
			cur_name = chk_name.pop_front();
			cur_got  = chk_got.pop_front();
			cur_exp  = chk_exp.pop_front();
			checks++;
			assert (cur_got === cur_exp)
			else begin
				errors++;
				$display("error at %0t: %s is %h, expected %h", $time, cur_name, cur_got,
					cur_exp);
			end
		end
	end

	always @(negedge clock) begin
		if (reset && sweep_done)
			done_pulses++;
	end

	initial begin
		logic [31:0] word;
		logic [31:0] status;
		logic        slverr;
		int          value;
		int          n;
		apb_req     = '0;
		errors      = 0;
		checks      = 0;
		done_pulses = 0;
		rho_val     = 0;
		for (n = 0; n < NODES; n++) begin
			model_prev[n] = 0;
			model_curr[n] = 0;
		end
		n = 0;
		while (reset !== 1'b1 && n < 20) begin
			@(negedge clock);
			n++;
		end
		if (reset !== 1'b1)
			report_timeout("reset was never released");

		// registers
		rho_val = 32'h8000 + ($random(seed) & 32'h3fff);    // about 0.25 to 0.375
		write_word(reg_addr(sel_rho), rho_val, 1'b0);
		set_edges($random(seed) % 2048, $random(seed) % 2048, $random(seed) % 2048,
			$random(seed) % 2048);
		check_reg("rho", sel_rho, rho_val);
		check_reg("edge right", sel_edge_right, edge_right);
		check_reg("edge left", sel_edge_left, edge_left);
		check_reg("edge up", sel_edge_up, edge_up);
		check_reg("edge down", sel_edge_down, edge_down);

		// initial displacement
		for (n = 0; n < NODES; n++) begin
			value = $random(seed) % 4096;
			write_word(node_addr(n), value, 1'b0);
			model_prev[n] = value;
			model_curr[n] = value;
		end
		check_nodes();

		// one sweep, fixed edges
		set_edges(0, 0, 0, 0);
		done_pulses = 0;
		write_word(reg_addr(sel_ctrl), 1, 1'b0);
		wait_idle(status);
		expect_value("status sweep count", status[31:16], 1);
		expect_value("sweep_done pulses", done_pulses, 1);
		model_sweep();
		check_nodes();

		// three sweeps with driven edges
		set_edges(1500 + ($random(seed) & 511), -1200 - ($random(seed) & 511),
			800 + ($random(seed) & 511), -600 - ($random(seed) & 511));
		done_pulses = 0;
		write_word(reg_addr(sel_ctrl), 3, 1'b0);
		wait_idle(status);
		expect_value("status sweep count", status[31:16], 3);
		expect_value("sweep_done pulses", done_pulses, 1);
		repeat (3) model_sweep();
		check_nodes();

		// refused starts and a node read held off by a run
		write_word(reg_addr(sel_ctrl), 0, 1'b1);    // empty run
		done_pulses = 0;
		write_word(reg_addr(sel_ctrl), 2, 1'b0);
		write_word(reg_addr(sel_ctrl), 5, 1'b1);    // already busy
		apb_transfer(1'b0, node_addr(6), '0, word, slverr);
		expect_value("sweep_done pulses before stalled read", done_pulses, 1);
		expect_value("pslverr of stalled read", 32'(slverr), 0);
		repeat (2) model_sweep();
		expect_value("prdata of stalled node read", word, sext(model_curr[6]));
		read_word(reg_addr(sel_status), status);
		expect_value("status after refused start", status, {16'd2, 16'd0});
		check_nodes();

		n = 0;
		while (chk_name.size() > 0 && n < 10) begin
			@(negedge clock);
			n++;
		end
		if (chk_name.size() > 0)
			report_timeout("compare queue did not drain");
		finish_run();
	end

endmodule

/* test/clock_gen.sv */
module clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// active low, released on a falling edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
	end

endmodule

/* design/patch_top.sv */
`include "patch_cfg.svh"

module patch_top (
	input  logic              clock,
	input  logic              reset,
	input  bus_pkg::apb_req_t apb_req,
	output bus_pkg::apb_rsp_t apb_rsp,
	output logic              sweep_done
);
	import bus_pkg::*;
	import wave_pkg::*;

	host_req_t          host_req;
	logic               host_ack;
	node_t              host_rdata;
	logic               start;
	logic [`ITER_W-1:0] iter_count;
	node_t              rho;
	edge_set_t          edges;
	logic               busy;
	logic [`ITER_W-1:0] sweeps_done_count;
	mem_req_t           mem_req;
	node_t              rdata;
	logic               rotate;
	update_ops_t        ops;
	logic               ops_valid;
	node_t              result;
	logic               result_valid;

	apb_regs i_apb_regs (
		.clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.host_req(host_req), .host_ack(host_ack), .host_rdata(host_rdata),
		.start(start), .iter_count(iter_count), .rho(rho), .edges(edges),
		.busy(busy), .sweeps_done_count(sweeps_done_count)
	);

	node_sweep i_node_sweep (
		.clock(clock), .reset(reset), .start(start), .iter_count(iter_count),
		.edges(edges), .host_req(host_req), .host_ack(host_ack), .host_rdata(host_rdata),
		.mem_req(mem_req), .rdata(rdata), .rotate(rotate), .ops(ops), .ops_valid(ops_valid),
		.result(result), .result_valid(result_valid), .busy(busy),
		.sweeps_done_count(sweeps_done_count), .sweep_done(sweep_done)
	);

	patch_memory i_patch_memory (
		.clock(clock), .reset(reset), .mem_req(mem_req), .rotate(rotate), .rdata(rdata)
	);

	node_update i_node_update (
		.clock(clock), .reset(reset), .ops(ops), .ops_valid(ops_valid), .rho(rho),
		.result(result), .result_valid(result_valid)
	);

endmodule

/* design/node_update.sv */
`include "patch_cfg.svh"

module node_update (
	input  logic                  clock,
	input  logic                  reset,
	input  wave_pkg::update_ops_t ops,
	input  logic                  ops_valid,
	input  wave_pkg::node_t       rho,
	output wave_pkg::node_t       result,
	output logic                  result_valid
);
	import wave_pkg::*;

	localparam int LAP_W  = `NODE_W + 3;    // room for four neighbors minus 4x center
	localparam int PROD_W = `NODE_W + LAP_W;

	logic signed [LAP_W-1:0]  lap;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] scaled;
	node_t                    next_val;

	always_comb begin
		lap = $signed(ops.right) + $signed(ops.left) + $signed(ops.up) + $signed(ops.down) -
			($signed(ops.center) <<< 2);
		prod   = lap * rho;
		scaled = prod >>> `RHO_FRAC;
		next_val = `NODE_W'(($signed(ops.center) <<< 1) - $signed(ops.prev) + scaled);    // wraps
	end

	always_ff @(posedge clock) begin
		if (!reset)
			result_valid <= 1'b0;
		else
			result_valid <= ops_valid;
	end

	always_ff @(posedge clock) begin
		if (ops_valid)
			result <= next_val;
	end

endmodule

/* design/patch_memory.sv */
`include "patch_cfg.svh"

module patch_memory (
	input  logic               clock,
	input  logic               reset,
	input  wave_pkg::mem_req_t mem_req,
	input  logic               rotate,
	output wave_pkg::node_t    rdata
);
	import wave_pkg::*;

	localparam int NODES = `PATCH_DIM * `PATCH_DIM;

	node_t                     planes [3][NODES];
	logic [1:0]                base;          // physical plane holding prev
	logic [2:0]                plane_sum;
	logic [1:0]                phys;
	logic [$bits(coord_t)-1:0] index;

	assign plane_sum = base + mem_req.plane;
	assign phys      = (plane_sum >= 3'd3) ? 2'(plane_sum - 3'd3) : plane_sum[1:0];
	assign index     = mem_req.coord;    // row major

	always_ff @(posedge clock) begin
		if (!reset) begin
			base <= 2'd0;
			for (int p = 0; p < 3; p++)
				for (int n = 0; n < NODES; n++)
					planes[p][n] <= '0;
		end else begin
			if (rotate)
				base <= (base == 2'd2) ? 2'd0 : base + 1'b1;    // curr becomes prev
			if (mem_req.valid && mem_req.write)
				planes[phys][index] <= mem_req.data;
		end
	end

	always_ff @(posedge clock) begin
		if (mem_req.valid && !mem_req.write)
			rdata <= planes[phys][index];
	end

	// a rotate moves the plane map, so no access may share its cycle
	a_rotate_quiet: assert property (@(posedge clock) disable iff (!reset)
		rotate |-> !mem_req.valid)
		else $error("memory access during plane rotation");

endmodule

/* design/node_sweep.sv */
`include "patch_cfg.svh"

module node_sweep (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  logic [`ITER_W-1:0]    iter_count,
	input  wave_pkg::edge_set_t   edges,
	input  bus_pkg::host_req_t    host_req,
	output logic                  host_ack,
	output wave_pkg::node_t       host_rdata,
	output wave_pkg::mem_req_t    mem_req,
	input  wave_pkg::node_t       rdata,
	output logic                  rotate,
	output wave_pkg::update_ops_t ops,
	output logic                  ops_valid,
	input  wave_pkg::node_t       result,
	input  logic                  result_valid,
	output logic                  busy,
	output logic [`ITER_W-1:0]    sweeps_done_count,
	output logic                  sweep_done
);
	import wave_pkg::*;

	typedef enum logic [2:0] {
		s_idle, s_host_wr, s_host_rd, s_read, s_compute, s_write, s_rotate
	} sweep_state_t;

	localparam int MAX_IDX = `PATCH_DIM - 1;

	// operand slots, also the bit order of the read mask
	localparam logic [2:0] ph_prev  = 3'd0;
	localparam logic [2:0] ph_curr  = 3'd1;
	localparam logic [2:0] ph_right = 3'd2;
	localparam logic [2:0] ph_left  = 3'd3;
	localparam logic [2:0] ph_up    = 3'd4;
	localparam logic [2:0] ph_down  = 3'd5;

	sweep_state_t state;
	coord_t       coord;
	coord_t       coord_inc;
	logic [5:0]   need;
	logic [2:0]   sel;
	logic         pend_valid;
	logic [2:0]   pend_sel;
	logic         node_begin;
	logic         last_node;
	logic         last_sweep;
	update_ops_t  ops_q;

	// edge nodes skip the reads that fall outside the patch
	function automatic logic [5:0] read_mask(coord_t c);
		read_mask = {c.row != MAX_IDX, c.row != 0, c.col != 0, c.col != MAX_IDX, 2'b11};
	endfunction

	function automatic logic [2:0] first_set(logic [5:0] m);
		first_set = ph_prev;
		for (int i = 5; i >= 0; i--)
			if (m[i])
				first_set = 3'(i);
	endfunction

	function automatic coord_t read_coord(coord_t c, logic [2:0] s);
		read_coord = c;
		case (s)
			ph_right: read_coord.col = c.col + 1'b1;
			ph_left:  read_coord.col = c.col - 1'b1;
			ph_up:    read_coord.row = c.row - 1'b1;
			ph_down:  read_coord.row = c.row + 1'b1;
			default: ;
		endcase
	endfunction

	assign sel        = first_set(need);
	assign coord_inc  = coord_t'(coord + 1'b1);    // row order walk
	assign last_node  = (coord.row == MAX_IDX) && (coord.col == MAX_IDX);
	assign last_sweep = (sweeps_done_count + 1'b1) == iter_count;
	assign node_begin = (state == s_idle && start) || (state == s_write && result_valid) ||
		(state == s_rotate);
	assign busy       = state inside {s_read, s_compute, s_write, s_rotate};
	assign ops_valid  = (state == s_compute);
	assign ops        = ops_q;
	assign host_rdata = rdata;

	always_comb begin
		mem_req  = '0;
		host_ack = 1'b0;
		rotate   = 1'b0;
		case (state)
			s_idle: begin
				if (host_req.valid && !start) begin    // write lands in prev first
					mem_req.valid = 1'b1;
					mem_req.write = host_req.write;
					mem_req.plane = host_req.write ? plane_prev : plane_curr;
					mem_req.coord = host_req.coord;
					mem_req.data  = host_req.data;
				end
			end
			s_host_wr: begin
				mem_req.valid = 1'b1;
				mem_req.write = 1'b1;
				mem_req.plane = plane_curr;
				mem_req.coord = host_req.coord;
				mem_req.data  = host_req.data;
				host_ack      = 1'b1;
			end
			s_host_rd: host_ack = 1'b1;    // rdata is valid now
			s_read: begin
				if (need != '0) begin
					mem_req.valid = 1'b1;
					mem_req.plane = (sel == ph_prev) ? plane_prev : plane_curr;
					mem_req.coord = read_coord(coord, sel);
				end
			end
			s_write: begin
				if (result_valid) begin
					mem_req.valid = 1'b1;
					mem_req.write = 1'b1;
					mem_req.plane = plane_next;
					mem_req.coord = coord;
					mem_req.data  = result;
				end
			end
			s_rotate: rotate = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			state             <= s_idle;
			coord             <= '0;
			need              <= '0;
			pend_valid        <= 1'b0;
			pend_sel          <= ph_prev;
			sweeps_done_count <= '0;
			sweep_done        <= 1'b0;
		end else begin
			sweep_done <= 1'b0;
			pend_valid <= (state == s_read) && (need != '0);
			pend_sel   <= sel;
			case (state)
				s_idle: begin
					if (start) begin
						coord             <= '0;
						need              <= read_mask('0);
						sweeps_done_count <= '0;
						state             <= s_read;
					end else if (host_req.valid) begin
						state <= host_req.write ? s_host_wr : s_host_rd;
					end
				end
				s_host_wr, s_host_rd: state <= s_idle;
				s_read: begin
					if (need != '0)
						need <= need & ~(6'b1 << sel);
					else
						state <= s_compute;    // last read captured this cycle
				end
				s_compute: state <= s_write;
				s_write: begin
					if (result_valid) begin
						if (last_node) begin
							state <= s_rotate;
						end else begin
							coord <= coord_inc;
							need  <= read_mask(coord_inc);
							state <= s_read;
						end
					end
				end
				s_rotate: begin
					sweeps_done_count <= sweeps_done_count + 1'b1;
					coord             <= '0;
					need              <= read_mask('0);
					if (last_sweep) begin
						sweep_done <= 1'b1;
						state      <= s_idle;
					end else begin
						state <= s_read;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// boundary values first, inside neighbors overwrite them
	always_ff @(posedge clock) begin
		if (node_begin) begin
			ops_q.right <= edges.right;
			ops_q.left  <= edges.left;
			ops_q.up    <= edges.up;
			ops_q.down  <= edges.down;
		end
		if (pend_valid) begin
			case (pend_sel)
				ph_prev:  ops_q.prev   <= rdata;
				ph_curr:  ops_q.center <= rdata;
				ph_right: ops_q.right  <= rdata;
				ph_left:  ops_q.left   <= rdata;
				ph_up:    ops_q.up     <= rdata;
				ph_down:  ops_q.down   <= rdata;
				default: ;
			endcase
		end
	end

	// host traffic only between runs, and apb_regs drops the request after the ack
	a_ack_idle: assert property (@(posedge clock) disable iff (!reset)
		host_ack |-> !busy ##1 !host_req.valid)
		else $error("host ack during a run or request held after ack");

endmodule

/* design/apb_regs.sv */
`include "patch_cfg.svh"

module apb_regs (
	input  logic                clock,
	input  logic                reset,
	input  bus_pkg::apb_req_t   apb_req,
	output bus_pkg::apb_rsp_t   apb_rsp,
	output bus_pkg::host_req_t  host_req,
	input  logic                host_ack,
	input  wave_pkg::node_t     host_rdata,
	output logic                start,
	output logic [`ITER_W-1:0]  iter_count,
	output wave_pkg::node_t     rho,
	output wave_pkg::edge_set_t edges,
	input  logic                busy,
	input  logic [`ITER_W-1:0]  sweeps_done_count
);
	import bus_pkg::*;
	import wave_pkg::*;

	apb_addr_u          addr;
	logic               setup;
	logic               access;
	logic               is_node;
	logic               reg_write;
	logic               ctrl_bad;
	logic               node_done;
	node_t              node_rdata;
	logic [`APB_DW-1:0] reg_rdata;

	assign addr      = apb_req.paddr;
	assign setup     = apb_req.psel && !apb_req.penable;
	assign access    = apb_req.psel && apb_req.penable;
	assign is_node   = addr.node_addr.node;
	assign reg_write = access && apb_req.pwrite && !is_node;
	assign ctrl_bad  = busy || (apb_req.pwdata[`ITER_W-1:0] == '0);    // no restart, no empty run

	always_ff @(posedge clock) begin
		if (!reset) begin
			host_req   <= '0;
			node_done  <= 1'b0;
			start      <= 1'b0;
			iter_count <= '0;
			rho        <= '0;
			edges      <= '0;
		end else begin
			start <= 1'b0;
			if (setup && is_node) begin    // node access goes to the sequencer
				host_req.valid <= 1'b1;
				host_req.write <= apb_req.pwrite;
				host_req.coord <= addr.node_addr.coord;
				host_req.data  <= apb_req.pwdata[`NODE_W-1:0];
			end
			if (host_ack) begin
				host_req.valid <= 1'b0;
				node_done      <= 1'b1;
			end
			if (access && is_node && node_done)
				node_done <= 1'b0;    // transfer completes this cycle
			if (reg_write) begin
				case (addr.reg_addr.sel)
					sel_ctrl: begin
						if (!ctrl_bad) begin
							iter_count <= apb_req.pwdata[`ITER_W-1:0];
							start      <= 1'b1;
						end
					end
					sel_rho:        rho        <= apb_req.pwdata[`NODE_W-1:0];
					sel_edge_right: edges.right <= apb_req.pwdata[`NODE_W-1:0];
					sel_edge_left:  edges.left  <= apb_req.pwdata[`NODE_W-1:0];
					sel_edge_up:    edges.up    <= apb_req.pwdata[`NODE_W-1:0];
					sel_edge_down:  edges.down  <= apb_req.pwdata[`NODE_W-1:0];
					default: ;    // status is read only
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (host_ack)
			node_rdata <= host_rdata;
	end

	always_comb begin
		reg_rdata = '0;
		case (addr.reg_addr.sel)
			sel_ctrl:       reg_rdata = `APB_DW'(iter_count);
			sel_status: begin
				reg_rdata[`APB_DW-1 -: `ITER_W] = sweeps_done_count;
				reg_rdata[0]                    = busy;
			end
			sel_rho:        reg_rdata = `APB_DW'($signed(rho));
			sel_edge_right: reg_rdata = `APB_DW'($signed(edges.right));
			sel_edge_left:  reg_rdata = `APB_DW'($signed(edges.left));
			sel_edge_up:    reg_rdata = `APB_DW'($signed(edges.up));
			sel_edge_down:  reg_rdata = `APB_DW'($signed(edges.down));
			default: ;
		endcase
	end

	assign apb_rsp.prdata  = is_node ? `APB_DW'($signed(node_rdata)) : reg_rdata;
	assign apb_rsp.pready  = !(access && is_node && !node_done);    // stall until node ack
	assign apb_rsp.pslverr = reg_write && (addr.reg_addr.sel == sel_ctrl) && ctrl_bad;

	// access phase must follow a setup phase
	a_penable_after_psel: assert property (@(posedge clock) disable iff (!reset)
		$rose(apb_req.penable) |-> $past(apb_req.psel))
		else $error("penable rose without a setup cycle");

endmodule

/* design/bus_pkg.sv */
`include "patch_cfg.svh"

package bus_pkg;

	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [`APB_AW-1:0] paddr;
		logic [`APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`APB_DW-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {
		sel_ctrl       = 3'd0,
		sel_status     = 3'd1,
		sel_rho        = 3'd2,
		sel_edge_right = 3'd3,
		sel_edge_left  = 3'd4,
		sel_edge_up    = 3'd5,
		sel_edge_down  = 3'd6
	} reg_sel_t;

	// bit 6 picks the view, bits 1:0 are byte lanes of a word
	typedef union packed {
		struct packed {
			logic             spare;
			logic             node;       // set for node region
			wave_pkg::coord_t coord;      // row in 5:4, column in 3:2
			logic [1:0]       byte_sel;
		} node_addr;
		struct packed {
			logic       spare;
			logic       node;             // clear for register region
			logic       pad;
			reg_sel_t   sel;
			logic [1:0] byte_sel;
		} reg_addr;
	} apb_addr_u;

	typedef struct packed {
		logic             valid;
		logic             write;
		wave_pkg::coord_t coord;
		wave_pkg::node_t  data;
	} host_req_t;

endpackage

/* design/wave_pkg.sv */
`include "patch_cfg.svh"

package wave_pkg;

	typedef logic signed [`NODE_W-1:0] node_t;    // one displacement sample

	typedef struct packed {
		logic [$clog2(`PATCH_DIM)-1:0] row;
		logic [$clog2(`PATCH_DIM)-1:0] col;
	} coord_t;

	// logical time planes, mapped to physical storage by patch_memory
	typedef enum logic [1:0] {
		plane_prev = 2'd0,
		plane_curr = 2'd1,
		plane_next = 2'd2
	} plane_t;

	typedef struct packed {
		logic   valid;
		logic   write;
		plane_t plane;
		coord_t coord;
		node_t  data;
	} mem_req_t;

	typedef struct packed {
		node_t center;    // curr plane, this node
		node_t prev;      // prev plane, this node
		node_t right;
		node_t left;
		node_t up;
		node_t down;
	} update_ops_t;

	typedef struct packed {
		node_t right;
		node_t left;
		node_t up;
		node_t down;
	} edge_set_t;

endpackage

/* design/patch_cfg.svh */
`ifndef PATCH_CFG_SVH
`define PATCH_CFG_SVH

// patch geometry
`define PATCH_DIM 4            // nodes per side

// node arithmetic
`define NODE_W 18              // signed node value width
`define RHO_FRAC 17            // fraction bits of rho

// host bus
`define APB_AW 8
`define APB_DW 32

`define ITER_W 16              // sweep count width

`endif
